// File: Makefile
SRCS := $(shell cat ooo_core.f)
SIM  := obj_dir/Vooo_core_tb

.PHONY: all run clean

all: run

$(SIM): ooo_core.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module ooo_core_tb -f ooo_core.f

run: $(SIM)
	$(SIM) +verilator+error+limit+100 > sim.log 2>&1; echo "exit status $$?" >> sim.log
	@cat sim.log
	@if grep -q "Test failures found" sim.log || grep -q "^exit status [1-9]" sim.log; then \
		echo "FAIL"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: hw/dispatch_alloc.sv
`timescale 1ns/1ps

module dispatch_alloc import ooo_pkg::*; #(
    parameter int ROB_DEPTH = 4
) (
    input  logic                                clk,
    input  logic                                rst,

    input  logic                                in_valid,
    input  issue_bundle_t                       in_bundle,
    output logic                                in_ready,

    input  logic                                alloc_ready,
    input  logic [$clog2(ROB_DEPTH)-1:0]        alloc_row,
    output logic                                alloc_valid,
    output logic [ID_WIDTH-1:0]                 alloc_slot_valid,
    output logic [ID_WIDTH-1:0][ARCH_IDX-1:0]   alloc_rd_arch,

    output logic [ID_WIDTH-1:0]                 lane_valid,
    output lane_req_t [ID_WIDTH-1:0]            lane_req,
    input  logic [ID_WIDTH-1:0]                 lane_ready
);

    localparam int ROB_IDX = $clog2(ROB_DEPTH * ID_WIDTH);

    logic any_valid;
    logic lanes_ok;
    logic fire;

    always_comb begin
        any_valid = 1'b0;
        lanes_ok  = 1'b1;
        for (int k = 0; k < ID_WIDTH; k++) begin
            any_valid = any_valid | in_bundle[k].valid;
            if (in_bundle[k].valid && !lane_ready[k]) begin
                lanes_ok = 1'b0;    // slot k must find its own lane free
            end
        end
    end

    assign in_ready = alloc_ready && lanes_ok;
    assign fire     = in_valid && in_ready;

    // an all-invalid bundle is taken but reserves no row
    assign alloc_valid = fire && any_valid;

    ////////////////////////////////////////////////////////////////////////////
    // split the bundle into lane requests

    always_comb begin
        for (int k = 0; k < ID_WIDTH; k++) begin
            alloc_slot_valid[k] = in_bundle[k].valid;
            alloc_rd_arch[k]    = in_bundle[k].rd_arch;
            lane_valid[k]       = alloc_valid && in_bundle[k].valid;
            lane_req[k].op      = in_bundle[k].op;
            lane_req[k].a       = in_bundle[k].a;
            lane_req[k].b       = in_bundle[k].b;
            lane_req[k].rob_id  = ROB_ID_W'(ROB_IDX'(int'(alloc_row) * ID_WIDTH + k));
        end
    end

endmodule

// File: hw/exec_lane.sv
`timescale 1ns/1ps

module exec_lane import ooo_pkg::*; #(
    parameter int MUL_LAT = 3
) (
    input  logic      clk,
    input  logic      rst,

    input  logic      req_valid,
    input  lane_req_t req,
    output logic      req_ready,

    output cdb_t      cdb
);

    localparam int CNT_W = $clog2(MUL_LAT + 1);

    logic                busy;
    logic [CNT_W-1:0]    cnt;       // cycles left before broadcast
    logic [ROB_ID_W-1:0] rob_id_q;
    logic [DATA_W-1:0]   result_q;

    logic [DATA_W-1:0]   result_d;
    logic [CNT_W-1:0]    lat_d;
    logic                fin;
    logic                take;

    always_comb begin
        lat_d = '0;                 // alu ops broadcast in the next cycle
        case (req.op)
            op_add: result_d = req.a + req.b;
            op_sub: result_d = req.a - req.b;
            op_xor: result_d = req.a ^ req.b;
            op_mul: begin
                result_d = DATA_W'(req.a * req.b);  // low word only
                lat_d    = CNT_W'(MUL_LAT - 1);
            end
            default: result_d = '0;
        endcase
    end

    assign fin       = busy && (cnt == '0);
    assign req_ready = !busy || fin;    // free again in the broadcast cycle
    assign take      = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (take) begin
            busy <= 1'b1;
            cnt  <= lat_d;
        end else if (fin) begin
            busy <= 1'b0;
        end else if (busy) begin
            cnt <= cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            rob_id_q <= req.rob_id;
            result_q <= result_d;
        end
    end

    assign cdb.valid  = fin;
    assign cdb.rob_id = rob_id_q;
    assign cdb.value  = result_q;

endmodule

// File: hw/ooo_core.sv
`timescale 1ns/1ps

module ooo_core import ooo_pkg::*; #(
    parameter int ROB_DEPTH = 4,
    parameter int MUL_LAT   = 3
) (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   in_valid,
    input  issue_bundle_t          in_bundle,
    output logic                   in_ready,

    output commit_t [ID_WIDTH-1:0] commit,
    output logic                   commit_valid,
    input  logic                   commit_ready
);

    logic                              alloc_valid;
    logic                              alloc_ready;
    logic [$clog2(ROB_DEPTH)-1:0]      alloc_row;
    logic [ID_WIDTH-1:0]               alloc_slot_valid;
    logic [ID_WIDTH-1:0][ARCH_IDX-1:0] alloc_rd_arch;

    logic [ID_WIDTH-1:0]               lane_valid;
    lane_req_t [ID_WIDTH-1:0]          lane_req;
    logic [ID_WIDTH-1:0]               lane_ready;
    cdb_t [ID_WIDTH-1:0]               cdb;     // one result bus per lane

    dispatch_alloc #(
        .ROB_DEPTH(ROB_DEPTH)
    ) u_dispatch (
        .clk             (clk),
        .rst             (rst),
        .in_valid        (in_valid),
        .in_bundle       (in_bundle),
        .in_ready        (in_ready),
        .alloc_ready     (alloc_ready),
        .alloc_row       (alloc_row),
        .alloc_valid     (alloc_valid),
        .alloc_slot_valid(alloc_slot_valid),
        .alloc_rd_arch   (alloc_rd_arch),
        .lane_valid      (lane_valid),
        .lane_req        (lane_req),
        .lane_ready      (lane_ready)
    );

    for (genvar k = 0; k < ID_WIDTH; k++) begin : g_lane
        exec_lane #(
            .MUL_LAT(MUL_LAT)
        ) u_lane (
            .clk      (clk),
            .rst      (rst),
            .req_valid(lane_valid[k]),
            .req      (lane_req[k]),
            .req_ready(lane_ready[k]),
            .cdb      (cdb[k])
        );
    end

    rob #(
        .ROB_DEPTH(ROB_DEPTH)
    ) u_rob (
        .clk             (clk),
        .rst             (rst),
        .alloc_valid     (alloc_valid),
        .alloc_slot_valid(alloc_slot_valid),
        .alloc_rd_arch   (alloc_rd_arch),
        .alloc_ready     (alloc_ready),
        .alloc_row       (alloc_row),
        .cdb             (cdb),
        .commit          (commit),
        .commit_valid    (commit_valid),
        .commit_ready    (commit_ready)
    );

endmodule

// File: hw/ooo_pkg.sv
package ooo_pkg;

    localparam int ID_WIDTH = 2;    // slots per bundle, row and commit
    localparam int DATA_W   = 32;
    localparam int ORDER_W  = 16;
    localparam int ARCH_IDX = 5;

    // rob_id field as carried on the lane and result buses, wide enough for 128 rows
    localparam int ROB_ID_W = 8;

    typedef enum logic [1:0] {
        op_add = 2'd0,
        op_sub = 2'd1,
        op_xor = 2'd2,
        op_mul = 2'd3
    } op_e;

    typedef struct packed {
        logic                valid;
        op_e                 op;
        logic [DATA_W-1:0]   a;
        logic [DATA_W-1:0]   b;
        logic [ARCH_IDX-1:0] rd_arch;
    } slot_t;

    typedef slot_t [ID_WIDTH-1:0] issue_bundle_t;

    typedef struct packed {
        op_e                 op;
        logic [DATA_W-1:0]   a;
        logic [DATA_W-1:0]   b;
        logic [ROB_ID_W-1:0] rob_id;
    } lane_req_t;

    typedef struct packed {
        logic                valid;
        logic [ROB_ID_W-1:0] rob_id;
        logic [DATA_W-1:0]   value;
    } cdb_t;

    typedef struct packed {
        logic                valid;
        logic [ORDER_W-1:0]  order;
        logic [ARCH_IDX-1:0] rd_arch;
        logic [DATA_W-1:0]   value;
    } commit_t;

endpackage

// File: hw/rob.sv
`timescale 1ns/1ps

module rob import ooo_pkg::*; #(
    parameter int ROB_DEPTH = 4
) (
    input  logic                                clk,
    input  logic                                rst,

    input  logic                                alloc_valid,
    input  logic [ID_WIDTH-1:0]                 alloc_slot_valid,
    input  logic [ID_WIDTH-1:0][ARCH_IDX-1:0]   alloc_rd_arch,
    output logic                                alloc_ready,
    output logic [$clog2(ROB_DEPTH)-1:0]        alloc_row,

    input  cdb_t [ID_WIDTH-1:0]                 cdb,

    output commit_t [ID_WIDTH-1:0]              commit,
    output logic                                commit_valid,
    input  logic                                commit_ready
);

    localparam int ROW_W   = $clog2(ROB_DEPTH);
    localparam int ROB_IDX = $clog2(ROB_DEPTH * ID_WIDTH);
    localparam int SLOT_W  = (ID_WIDTH > 1) ? $clog2(ID_WIDTH) : 1;

    typedef struct packed {
        logic                valid;
        logic                done;
        logic [ARCH_IDX-1:0] rd_arch;
        logic [DATA_W-1:0]   value;
    } entry_t;

    entry_t             rows [ROB_DEPTH][ID_WIDTH];

    logic [ROW_W:0]     head_q;     // msb is the wrap bit
    logic [ROW_W:0]     tail_q;
    logic [ORDER_W-1:0] order_q;

    logic [ROW_W-1:0]   head_row;
    logic [ROW_W-1:0]   tail_row;
    logic               full;
    logic               empty;
    logic               row_done;
    logic               retire;
    logic [ORDER_W-1:0] row_cnt;    // valid slots in the head row

    logic [ROB_IDX-1:0] snoop_id   [ID_WIDTH];
    logic [ROW_W-1:0]   snoop_row  [ID_WIDTH];
    logic [SLOT_W-1:0]  snoop_slot [ID_WIDTH];

    assign head_row = head_q[ROW_W-1:0];
    assign tail_row = tail_q[ROW_W-1:0];

    assign empty = (head_q == tail_q);
    assign full  = (head_row == tail_row) && (head_q[ROW_W] != tail_q[ROW_W]);

    assign alloc_ready = !full;
    assign alloc_row   = tail_row;

    always_comb begin
        for (int k = 0; k < ID_WIDTH; k++) begin
            snoop_id[k]   = cdb[k].rob_id[ROB_IDX-1:0];
            snoop_row[k]  = ROW_W'(snoop_id[k] / ID_WIDTH);
            snoop_slot[k] = SLOT_W'(snoop_id[k] % ID_WIDTH);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // allocate, snoop, retire

    assign retire = commit_valid && commit_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < ROB_DEPTH; r++) begin
                for (int i = 0; i < ID_WIDTH; i++) begin
                    rows[r][i].valid <= 1'b0;
                    rows[r][i].done  <= 1'b0;
                end
            end
            head_q  <= '0;
            tail_q  <= '0;
            order_q <= '0;
        end else begin
            if (alloc_valid) begin      // fullness already checked by dispatch
                tail_q <= tail_q + 1'b1;
                for (int i = 0; i < ID_WIDTH; i++) begin
                    rows[tail_row][i].valid   <= alloc_slot_valid[i];
                    rows[tail_row][i].done    <= 1'b0;
                    rows[tail_row][i].rd_arch <= alloc_rd_arch[i];
                end
            end

            for (int k = 0; k < ID_WIDTH; k++) begin
                if (cdb[k].valid) begin
                    rows[snoop_row[k]][snoop_slot[k]].done  <= 1'b1;
                    rows[snoop_row[k]][snoop_slot[k]].value <= cdb[k].value;
                end
            end

            if (retire) begin
                head_q  <= head_q + 1'b1;
                order_q <= order_q + row_cnt;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // commit port, straight from the head row

    always_comb begin
        row_cnt  = '0;
        row_done = !empty;
        for (int i = 0; i < ID_WIDTH; i++) begin
            row_done = row_done && (rows[head_row][i].done || !rows[head_row][i].valid);
            commit[i].order   = order_q + row_cnt;
            commit[i].rd_arch = rows[head_row][i].rd_arch;
            commit[i].value   = rows[head_row][i].value;
            if (rows[head_row][i].valid) begin
                row_cnt = row_cnt + 1'b1;
            end
        end
        for (int i = 0; i < ID_WIDTH; i++) begin
            commit[i].valid = row_done && rows[head_row][i].valid;
        end
    end

    assign commit_valid = row_done;

endmodule

// File: ooo_core.f
hw/ooo_pkg.sv
hw/dispatch_alloc.sv
hw/exec_lane.sv
hw/rob.sv
hw/ooo_core.sv
tests/ooo_core_chk.sv
tests/ooo_core_mon.sv
tests/ooo_core_tb.sv

// File: tests/ooo_core_chk.sv
`timescale 1ns/1ps

module ooo_core_chk import ooo_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  commit_t [ID_WIDTH-1:0] commit,
    input  logic                   commit_valid,
    input  logic                   commit_ready
);

    int                 fails = 0;
    logic [ORDER_W-1:0] next_order;     // order due on slot 0 of the next row
    logic [ORDER_W-1:0] row_valid;

    always_comb begin
        row_valid = '0;
        for (int i = 0; i < ID_WIDTH; i++) begin
            row_valid = row_valid + ORDER_W'(commit[i].valid);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            next_order <= '0;
        end else if (commit_valid && commit_ready) begin
            next_order <= commit[0].order + row_valid;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // port rules

    quiet_after_reset: assert property (@(posedge clk) $past(rst) |-> !commit_valid)
        else begin
            $error("commit_valid high during reset or in the cycle after it");
            fails++;
        end

    hold_when_stalled: assert property (@(posedge clk) disable iff (rst)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit))
        else begin
            $error("commit records changed while the commit port was stalled");
            fails++;
        end

    order_steps: assert property (@(posedge clk) disable iff (rst)
        commit_valid && commit_ready |-> commit[0].order == next_order)
        else begin
            $error("retired row does not continue the order count");
            fails++;
        end

endmodule

bind ooo_core ooo_core_chk u_chk (
    .clk         (clk),
    .rst         (rst),
    .commit      (commit),
    .commit_valid(commit_valid),
    .commit_ready(commit_ready)
);

// File: tests/ooo_core_mon.sv
`timescale 1ns/1ps

module ooo_core_mon import ooo_pkg::*; #(
    parameter int ROB_DEPTH = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  issue_bundle_t          in_bundle,
    input  logic                   in_ready,
    input  commit_t [ID_WIDTH-1:0] commit,
    input  logic                   commit_valid,
    input  logic                   commit_ready,
    input  int                     test_id,
    input  logic                   report,
    output int                     pending,
    output int                     errors
);

    logic [ID_WIDTH-1:0] mask_q [$];   // valid slots of each outstanding row
    int                  tag_q  [$];
    commit_t             slot_q [$];   // expected retirements in program order
    logic [ORDER_W-1:0]  next_order;
    int                  cur_tag  = -1;
    int                  cur_rows = 0;
    int                  cur_errs = 0;
    int                  n_tests  = 0;
    int                  n_bad    = 0;
    int                  n_rows   = 0;

    initial begin
        pending = 0;
        errors  = 0;
    end

    function automatic logic [DATA_W-1:0] expect_value(input op_e op,
                                                       input logic [DATA_W-1:0] a,
                                                       input logic [DATA_W-1:0] b);
        logic [2*DATA_W-1:0] prod;
        prod = {{DATA_W{1'b0}}, a} * {{DATA_W{1'b0}}, b};
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_xor:  return a ^ b;
            default: return prod[DATA_W-1:0];   // low word of the full product
        endcase
    endfunction

    task automatic compare_field(input string name, input int idx,
                                 input logic [DATA_W-1:0] exp, input logic [DATA_W-1:0] act);
        if (exp !== act) begin
            errors++;
            cur_errs++;
            $display("error: commit[%0d].%s expected %h got %h", idx, name, exp, act);
        end
    endtask

    task automatic close_test();
        if (cur_rows > 0) begin
            $display("test %0d finished: %0d rows retired, %0d errors", cur_tag, cur_rows, cur_errs);
            n_tests++;
            if (cur_errs != 0) begin
                n_bad++;
            end
        end
        cur_rows = 0;
        cur_errs = 0;
    endtask

    task automatic accept_bundle();
        logic [ID_WIDTH-1:0] mask;
        commit_t             e;
        mask = '0;
        for (int i = 0; i < ID_WIDTH; i++) begin
            if (in_bundle[i].valid) begin
                mask[i]   = 1'b1;
                e.valid   = 1'b1;
                e.order   = next_order;
                e.rd_arch = in_bundle[i].rd_arch;
                e.value   = expect_value(in_bundle[i].op, in_bundle[i].a, in_bundle[i].b);
                slot_q.push_back(e);
                next_order++;
            end
        end
        if (mask != '0) begin       // all-invalid bundles leave no row behind
            mask_q.push_back(mask);
            tag_q.push_back(test_id);
        end
    endtask

    task automatic retire_row();
        logic [ID_WIDTH-1:0] mask;
        int                  tag;
        commit_t             e;
        if (mask_q.size() == 0) begin
            errors++;
            $display("error: a row retired while no bundle was outstanding");
            return;
        end
        mask = mask_q.pop_front();
        tag  = tag_q.pop_front();
        if (tag != cur_tag) begin
            close_test();
            cur_tag = tag;
        end
        cur_rows++;
        n_rows++;
        for (int i = 0; i < ID_WIDTH; i++) begin
            compare_field("valid", i, DATA_W'(mask[i]), DATA_W'(commit[i].valid));
            if (mask[i]) begin
                e = slot_q.pop_front();
                compare_field("order", i, DATA_W'(e.order), DATA_W'(commit[i].order));
                compare_field("rd_arch", i, DATA_W'(e.rd_arch), DATA_W'(commit[i].rd_arch));
                compare_field("value", i, e.value, commit[i].value);
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            next_order = '0;
        end else begin
            if (pending == ROB_DEPTH && in_ready) begin
                errors++;
                cur_errs++;
                $display("error: in_ready expected %h got %h with the rob full", 1'b0, in_ready);
            end
            if (commit_valid && commit_ready) retire_row();
            if (in_valid && in_ready) accept_bundle();
            pending = mask_q.size();
        end
    end

    always @(posedge report) begin
        close_test();
        if (pending != 0) begin
            errors++;
            $display("error: %0d expected rows were never retired", pending);
        end
        $display("summary: %0d tests, %0d failed, %0d rows retired, %0d errors",
                 n_tests, n_bad, n_rows, errors);
    end

endmodule

// File: tests/ooo_core_tb.sv
`timescale 1ns/1ps

module ooo_core_tb import ooo_pkg::*; ();

    localparam int ROB_DEPTH = 4;
    localparam int MUL_LAT   = 3;

    localparam logic [1:0] STALL_NONE = 2'd0;
    localparam logic [1:0] STALL_RAND = 2'd1;   // commit_ready from the lfsr
    localparam logic [1:0] STALL_HOLD = 2'd2;   // commit_ready held low
    localparam slot_t      NO_OP      = '0;

    typedef struct packed {
        issue_bundle_t bundle;
        logic [1:0]    stall;
        logic          rnd;     // operands drawn from the lfsr at drive time
        logic [7:0]    test;
    } stim_t;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   in_valid;
    issue_bundle_t          in_bundle;
    logic                   in_ready;
    commit_t [ID_WIDTH-1:0] commit;
    logic                   commit_valid;
    logic                   commit_ready;
    logic                   report;
    int                     cur_test;
    int                     pending;
    int                     mon_errors;
    logic [15:0]            lfsr;
    logic [1:0]             stall_mode;
    stim_t                  table_q [$];
    logic                   table_ready = 1'b0;
    int                     limit_ns;

    always #10 clk = ~clk;

    ooo_core #(.ROB_DEPTH(ROB_DEPTH), .MUL_LAT(MUL_LAT)) u_dut (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .in_bundle(in_bundle), .in_ready(in_ready),
        .commit(commit), .commit_valid(commit_valid), .commit_ready(commit_ready)
    );

    ooo_core_mon #(.ROB_DEPTH(ROB_DEPTH)) u_mon (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .in_bundle(in_bundle), .in_ready(in_ready),
        .commit(commit), .commit_valid(commit_valid), .commit_ready(commit_ready),
        .test_id(cur_test), .report(report), .pending(pending), .errors(mon_errors)
    );

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16 + x^14 + x^13 + x^11 + 1
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic rand_slot(output slot_t s);
        logic [31:0] r;
        take_bits(2, r);
        s.valid = |r[1:0];
        take_bits(2, r);
        s.op = op_e'(r[1:0]);
        take_bits(32, r);
        s.a = r;
        take_bits(32, r);
        s.b = r;
        take_bits(ARCH_IDX, r);
        s.rd_arch = r[ARCH_IDX-1:0];
    endtask

    function automatic slot_t op_slot(input op_e op, input logic [31:0] a,
                                      input logic [31:0] b, input logic [4:0] rd);
        slot_t s;
        s.valid   = 1'b1;
        s.op      = op;
        s.a       = a;
        s.b       = b;
        s.rd_arch = rd;
        return s;
    endfunction

    function automatic issue_bundle_t pair(input slot_t s0, input slot_t s1);
        issue_bundle_t b;
        b[0] = s0;
        b[1] = s1;
        return b;
    endfunction

    task automatic add_entry(input issue_bundle_t b, input logic [1:0] stall,
                             input logic rnd, input int test);
        stim_t e;
        e.bundle = b;
        e.stall  = stall;
        e.rnd    = rnd;
        e.test   = 8'(test);
        table_q.push_back(e);
    endtask

    task automatic load_table();
        // test 1 exercises every op with wrap-around operands
        add_entry(pair(op_slot(op_add, 32'hffff_ffff, 32'h0000_0001, 5'd1),
                       op_slot(op_sub, 32'h0000_0000, 32'h0000_0001, 5'd2)), STALL_NONE, 1'b0, 1);
        add_entry(pair(op_slot(op_xor, 32'ha5a5_f00f, 32'h5a5a_0ff0, 5'd3),
                       op_slot(op_add, 32'h1234_5678, 32'h8765_4321, 5'd4)), STALL_NONE, 1'b0, 1);
        add_entry(pair(op_slot(op_mul, 32'h0001_0001, 32'hffff_ffff, 5'd5),
                       op_slot(op_sub, 32'h8000_0000, 32'h7fff_ffff, 5'd6)), STALL_NONE, 1'b0, 1);
        add_entry(pair(op_slot(op_mul, 32'd7, 32'd6, 5'd7),
                       op_slot(op_mul, 32'hdead_beef, 32'h1234_5678, 5'd8)), STALL_NONE, 1'b0, 1);
        // test 2 puts a slow multiply ahead of fast alu work
        add_entry(pair(op_slot(op_mul, 32'h0000_ffff, 32'h0001_0000, 5'd9),
                       op_slot(op_add, 32'd10, 32'd20, 5'd10)), STALL_NONE, 1'b0, 2);
        // lane 1 only, so these rows complete while the multiply is still running
        add_entry(pair(NO_OP, op_slot(op_sub, 32'd50, 32'd8, 5'd11)), STALL_NONE, 1'b0, 2);
        add_entry(pair(NO_OP, op_slot(op_xor, 32'hffff_0000, 32'h00ff_ff00, 5'd12)),
                  STALL_NONE, 1'b0, 2);
        add_entry(pair(op_slot(op_add, 32'd1, 32'd2, 5'd13),
                       op_slot(op_sub, 32'd3, 32'd4, 5'd14)), STALL_NONE, 1'b0, 2);
        // test 3 issues partial and empty bundles
        add_entry(pair(NO_OP, op_slot(op_add, 32'd100, 32'd23, 5'd15)), STALL_NONE, 1'b0, 3);
        add_entry(pair(op_slot(op_xor, 32'h0f0f_0f0f, 32'h3333_3333, 5'd16), NO_OP),
                  STALL_NONE, 1'b0, 3);
        add_entry(pair(NO_OP, NO_OP), STALL_NONE, 1'b0, 3);
        add_entry(pair(op_slot(op_mul, 32'h8000_0000, 32'd2, 5'd17), NO_OP), STALL_NONE, 1'b0, 3);
        // test 4 fills the rob behind a stalled commit port
        for (int i = 0; i < ROB_DEPTH; i++) begin
            add_entry(pair(op_slot(op_add, 32'(i), 32'h100, 5'(i)),
                           op_slot(op_xor, 32'(i * 3), 32'hff, 5'(i + 8))), STALL_HOLD, 1'b0, 4);
        end
        // test 5 runs a long random stream with random stalls
        for (int i = 0; i < 16; i++) begin
            add_entry('0, STALL_RAND, 1'b1, 5);
        end
    endtask

    task automatic step_cycle();
        logic [31:0] r;
        @(posedge clk);
        #1;
        case (stall_mode)
            STALL_RAND: begin
                take_bits(1, r);
                commit_ready = r[0];
            end
            STALL_HOLD: commit_ready = 1'b0;
            default:    commit_ready = 1'b1;
        endcase
    endtask

    task automatic drain();
        stall_mode = STALL_NONE;
        while (pending != 0) step_cycle();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // driver

    initial begin
        stim_t e;
        slot_t s;
        logic  ok;
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_bundle    = '0;
        commit_ready = 1'b1;
        report       = 1'b0;
        cur_test     = 0;
        stall_mode   = STALL_NONE;
        lfsr         = 16'd43672;
        load_table();
        limit_ns    = (table_q.size() + 20) * (MUL_LAT + ROB_DEPTH) * 20;
        table_ready = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int n = 0; n < table_q.size(); n++) begin
            e = table_q[n];
            if (e.stall == STALL_HOLD && (n == 0 || table_q[n-1].stall != STALL_HOLD)) begin
                drain();    // start the fill from an empty rob
            end
            stall_mode = e.stall;
            if (e.rnd) begin
                for (int k = 0; k < ID_WIDTH; k++) begin
                    rand_slot(s);
                    e.bundle[k] = s;
                end
            end
            cur_test  = e.test;
            in_bundle = e.bundle;
            in_valid  = 1'b1;
            ok        = 1'b0;
            while (!ok) begin
                @(negedge clk);
                ok = in_ready;
                step_cycle();
            end
            in_valid = 1'b0;
            if (e.stall == STALL_HOLD &&
                (n + 1 == table_q.size() || table_q[n+1].stall != STALL_HOLD)) begin
                repeat (3) step_cycle();    // rob full, in_ready must stay low
            end
        end

        drain();
        report = 1'b1;
        @(posedge clk);
        if (mon_errors == 0 && u_dut.u_chk.fails == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin : watchdog
        wait (table_ready);
        #(limit_ns);
        $display("timeout: the run did not finish within %0d ns, the core looks hung", limit_ns);
        $display("Test failures found");
        $finish;
    end

endmodule
